/* Bender.yml */
package:
  name: axi2axil

sources:
  - include_dirs:
      - source
    files:
      - source/axi2axil_pkg.sv
      - source/resp_tracker_fifo.sv
      - source/axi2axil_core.sv
      - source/axi2axil_bridge.sv

  - target: test
    include_dirs:
      - source
    files:
      - dv/axi2axil_checker.sv
      - dv/axi2axil_tb.sv

/* dv/axi2axil_cases.txt */
# dir addr id len size burst err_beat exp_resp, all hex, burst 0 FIXED 1 INCR 2 WRAP
# err_beat ff means every beat is OKAY, exp_resp is the merged b code and 0 on reads
W 0100 1 03 2 1 ff 0
R 0100 2 03 2 1 ff 0
W 0200 3 07 2 1 02 2
R 0304 4 00 2 1 ff 0
W 0408 5 03 2 0 00 2
R 0408 6 05 2 0 03 0
W 0538 7 07 2 2 07 2
R 0514 8 03 2 2 ff 0
W 0602 9 0f 1 2 ff 0
R 0701 a 01 0 2 01 0
W 7ff0 b 03 2 1 ff 0
R 0800 c 10 0 1 05 0
W 0900 d 0f 2 1 0a 2
R 0900 e 0f 2 1 ff 0

/* dv/axi2axil_checker.sv */
// AXI4 to AXI4-Lite bridge checker
// Builds the expected beats of every burst and compares both sides of the DUT
`include "axi2axil_settings.svh"

module axi2axil_checker import axi2axil_pkg::*; (
  input logic       clk,
  input logic       rst,
  // AXI4 side
  input logic       aw_valid, aw_ready,
  input axi_wdata_t w,
  input logic       w_valid, w_ready,
  input axi_resp_t  b,
  input logic       b_valid, b_ready,
  input logic       ar_valid, ar_ready,
  input axi_resp_t  r,
  input logic       r_valid, r_ready,
  // AXI-Lite side
  input axil_req_t  axil_aw,
  input logic       axil_aw_valid, axil_aw_ready,
  input axi_wdata_t axil_w,
  input logic       axil_w_valid, axil_w_ready,
  input logic       axil_b_valid, axil_b_ready,
  input axil_req_t  axil_ar,
  input logic       axil_ar_valid, axil_ar_ready,
  input axil_resp_t axil_r,
  input logic       axil_r_valid, axil_r_ready
);

  int        errors = 0;
  int        bursts_done = 0;
  int        rst_cycles = 0;
  axil_req_t aw_exp_q[$];
  axil_req_t ar_exp_q[$];
  axi_resp_t b_exp_q[$];
  axi_resp_t r_exp_q[$];
  axi_resp_t exp_r;
  // Last-beat flag of every write beat in issue order
  logic      wlast_q[$];
  // Slave read data in axil_r order
  logic [`AXI2AXIL_DATA_W-1:0] rdata_q[$];

  task automatic report_problem(input string what);
    errors++;
    $display("t=%0t %s", $time, what);
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
    if (exp !== got) begin
      errors++;
      $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, got);
    end
  endtask

  // Expected address of one beat
  function automatic logic [`AXI2AXIL_ADDR_W-1:0] expected_addr(input axi_req_t req,
                                                                input int beat);
    int bytes;
    int window;
    int base;
    bytes  = 1 << req.size;
    window = (req.len + 1) * bytes;
    base   = (req.addr / window) * window;
    case (req.burst)
      FIXED:   expected_addr = req.addr;
      WRAP:    expected_addr = base + (req.addr - base + beat * bytes) % window;
      default: expected_addr = req.addr + beat * bytes;
    endcase
  endfunction

  // Called by the testbench once per case line
  task automatic expect_burst(input logic is_write, input axi_req_t req,
                              input logic [7:0] err_beat, input resp_e exp_resp);
    axil_req_t beat;
    axi_resp_t resp;
    int        i;
    for (i = 0; i <= req.len; i++) begin
      beat.addr = expected_addr(req, i);
      beat.prot = req.prot;
      beat.user = req.user;
      if (is_write) begin
        aw_exp_q.push_back(beat);
        wlast_q.push_back(i == req.len);
      end else begin
        ar_exp_q.push_back(beat);
        // Data filled in from the slave side
        resp = '{id: req.id, user: beat.addr[5:2], resp: (i == err_beat) ? SLVERR : OKAY,
                 data: '0, last: (i == req.len)};
        r_exp_q.push_back(resp);
      end
    end
    // One b per burst with the user of its last beat
    if (is_write) begin
      resp = '{id: req.id, user: beat.addr[5:2], resp: exp_resp, data: '0, last: 1'b1};
      b_exp_q.push_back(resp);
    end
  endtask

  task automatic report_leftovers();
    int left;
    left = aw_exp_q.size() + ar_exp_q.size() + b_exp_q.size() + r_exp_q.size() +
           wlast_q.size();
    if (left != 0) begin
      report_problem($sformatf("%0d expected beats or responses never arrived", left));
    end
    if (rdata_q.size() != 0) begin
      report_problem("read data from the slave was never forwarded on r");
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      rst_cycles++;
      // State is unknown before the first edge
      if (rst_cycles > 1) begin
        compare_value("axil_aw_valid,axil_ar_valid,b_valid,r_valid", 64'd0,
                      {axil_aw_valid, axil_ar_valid, b_valid, r_valid});
      end
    end else begin
      // ------------------------------------------------------------------
      // Request side
      // ------------------------------------------------------------------
      // Beat 0 leaves in the cycle the request is taken
      if (aw_valid && aw_ready && !(axil_aw_valid && axil_aw_ready)) begin
        report_problem("aw accepted without its first axil_aw beat");
      end
      if (ar_valid && ar_ready && !(axil_ar_valid && axil_ar_ready)) begin
        report_problem("ar accepted without its first axil_ar beat");
      end
      if (axil_aw_valid && axil_aw_ready) begin
        if (aw_exp_q.size() == 0) begin
          report_problem("axil_aw beat with no write burst pending");
        end else begin
          compare_value("axil_aw", aw_exp_q.pop_front(), axil_aw);
        end
      end
      if (axil_ar_valid && axil_ar_ready) begin
        if (ar_exp_q.size() == 0) begin
          report_problem("axil_ar beat with no read burst pending");
        end else begin
          compare_value("axil_ar", ar_exp_q.pop_front(), axil_ar);
        end
      end
      // Write data straight through
      compare_value("axil_w_valid", w_valid, axil_w_valid);
      compare_value("w_ready", axil_w_ready, w_ready);
      if (w_valid) begin
        compare_value("axil_w", w, axil_w);
      end
      // ------------------------------------------------------------------
      // Response side
      // ------------------------------------------------------------------
      // Read responses pass straight through
      compare_value("r_valid", axil_r_valid, r_valid);
      compare_value("axil_r_ready", r_ready, axil_r_ready);
      // Only the last write beat raises b and waits for b_ready
      if (axil_b_valid) begin
        if (wlast_q.size() == 0) begin
          report_problem("axil_b response with no write beat pending");
        end else begin
          if (wlast_q[0]) begin
            compare_value("b_valid", 1'b1, b_valid);
            compare_value("axil_b_ready", b_ready, axil_b_ready);
          end else begin
            compare_value("b_valid", 1'b0, b_valid);
            compare_value("axil_b_ready", 1'b1, axil_b_ready);
          end
          if (axil_b_ready) begin
            wlast_q.delete(0);
          end
        end
      end else begin
        compare_value("b_valid", 1'b0, b_valid);
      end
      if (axil_r_valid && axil_r_ready) begin
        rdata_q.push_back(axil_r.data);
      end
      if (r_valid && r_ready) begin
        if (r_exp_q.size() == 0 || rdata_q.size() == 0) begin
          report_problem("r beat with no read beat pending");
        end else begin
          exp_r = r_exp_q.pop_front();
          exp_r.data = rdata_q.pop_front();
          compare_value("r", exp_r, r);
          if (exp_r.last) bursts_done++;
        end
      end
      if (b_valid && b_ready) begin
        if (b_exp_q.size() == 0) begin
          report_problem("b response with no write burst pending");
        end else begin
          compare_value("b", b_exp_q.pop_front(), b);
          bursts_done++;
        end
      end
    end
  end

endmodule

/* dv/axi2axil_tb.sv */
// AXI4 to AXI4-Lite bridge testbench
// Bursts from the case file, AXI-Lite slave model with random stalls, run limit
`include "axi2axil_settings.svh"

module axi2axil_tb import axi2axil_pkg::*; ();

  typedef struct packed {
    logic        is_write;
    axi_req_t    req;
    logic [7:0]  err_beat;
    resp_e       exp_resp;
  } case_t;

  logic       clk = 1'b0;
  logic       rst;
  axi_req_t   aw, ar;
  logic       aw_valid, aw_ready, ar_valid, ar_ready;
  axi_wdata_t w, axil_w;
  logic       w_valid, w_ready, axil_w_valid;
  axi_resp_t  b, r;
  logic       b_valid, r_valid;
  axil_req_t  axil_aw, axil_ar;
  logic       axil_aw_valid, axil_ar_valid, axil_b_ready, axil_r_ready;
  // Driven by the slave model
  logic       axil_aw_ready = 1'b0, axil_w_ready = 1'b0, axil_ar_ready = 1'b0;
  logic       b_ready = 1'b0, r_ready = 1'b0;
  logic       axil_b_valid = 1'b0, axil_r_valid = 1'b0;
  axil_resp_t axil_b = '0, axil_r = '0;

  case_t      cases[$];
  int         limit = 200;
  int         cycles = 0;

  axi2axil_bridge axi2axil_bridge_i (.*);
  axi2axil_checker checker_i (.*);

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // AXI-Lite slave model and AXI4 response sink
  // ----------------------------------------------------------------------

  logic [`AXI2AXIL_DATA_W-1:0] mem [2**(`AXI2AXIL_ADDR_W-2)];
  axil_req_t  slv_aw_q[$];
  axi_wdata_t slv_w_q[$];
  axil_resp_t slv_b_q[$];
  axil_resp_t slv_r_q[$];
  // Per-beat response codes, in issue order
  resp_e      wr_err_q[$];
  resp_e      rd_err_q[$];
  logic       b_hs;
  logic       r_hs;
  axil_req_t  wr_req;
  axi_wdata_t wr_beat;
  axil_resp_t rsp;

  always @(posedge clk) begin
    b_hs = axil_b_valid && axil_b_ready;
    r_hs = axil_r_valid && axil_r_ready;
    if (b_hs) slv_b_q.delete(0);
    if (r_hs) slv_r_q.delete(0);
    if (axil_aw_valid && axil_aw_ready) slv_aw_q.push_back(axil_aw);
    if (axil_w_valid && axil_w_ready) slv_w_q.push_back(axil_w);
    if (axil_ar_valid && axil_ar_ready) begin
      rsp.resp = rd_err_q.pop_front();
      rsp.user = axil_ar.addr[5:2];
      rsp.data = mem[axil_ar.addr[`AXI2AXIL_ADDR_W-1:2]];
      slv_r_q.push_back(rsp);
    end
    // Address and data pair up in order
    if (slv_aw_q.size() != 0 && slv_w_q.size() != 0) begin
      wr_req  = slv_aw_q.pop_front();
      wr_beat = slv_w_q.pop_front();
      for (int k = 0; k < `AXI2AXIL_DATA_W / 8; k++) begin
        if (wr_beat.strb[k]) mem[wr_req.addr[`AXI2AXIL_ADDR_W-1:2]][8*k +: 8] =
          wr_beat.data[8*k +: 8];
      end
      rsp.resp = wr_err_q.pop_front();
      rsp.user = wr_req.addr[5:2];
      rsp.data = '0;
      slv_b_q.push_back(rsp);
    end
    #1;
    axil_aw_ready = ($urandom_range(3) != 0);
    axil_w_ready  = ($urandom_range(3) != 0);
    axil_ar_ready = ($urandom_range(3) != 0);
    b_ready       = ($urandom_range(3) != 0);
    r_ready       = ($urandom_range(3) != 0);
    // Valid holds until its handshake
    if (!axil_b_valid || b_hs) axil_b_valid = (slv_b_q.size() != 0) && ($urandom_range(2) != 0);
    if (axil_b_valid) axil_b = slv_b_q[0];
    if (!axil_r_valid || r_hs) axil_r_valid = (slv_r_q.size() != 0) && ($urandom_range(2) != 0);
    if (axil_r_valid) axil_r = slv_r_q[0];
  end

  // ----------------------------------------------------------------------
  // Case loading and AXI4 stimulus
  // ----------------------------------------------------------------------

  task automatic load_case(input int dir, input int a, input int id, input int len,
                           input int sz, input int bt, input int eb, input int er);
    case_t c;
    int    i;
    c.is_write  = (dir == "W");
    c.req.addr  = a[`AXI2AXIL_ADDR_W-1:0];
    c.req.id    = id[`AXI2AXIL_ID_W-1:0];
    c.req.len   = len[7:0];
    c.req.size  = sz[2:0];
    c.req.burst = burst_type_e'(bt[1:0]);
    // Sideband taken from the id
    c.req.prot  = c.req.id[2:0];
    c.req.user  = ~c.req.id;
    c.err_beat  = eb[7:0];
    c.exp_resp  = resp_e'(er[1:0]);
    cases.push_back(c);
    for (i = 0; i <= len; i++) begin
      if (c.is_write) wr_err_q.push_back((i == eb) ? SLVERR : OKAY);
      else rd_err_q.push_back((i == eb) ? SLVERR : OKAY);
    end
    checker_i.expect_burst(c.is_write, c.req, c.err_beat, c.exp_resp);
    limit += 20 * (len + 1);
  endtask

  task automatic drive_writes();
    int k;
    int i;
    for (k = 0; k < cases.size(); k++) begin
      if (cases[k].is_write) begin
        aw = cases[k].req;
        aw_valid = 1'b1;
        @(posedge clk);
        while (!aw_ready) @(posedge clk);
        #1;
        aw_valid = 1'b0;
        // Data beats after the address
        for (i = 0; i <= cases[k].req.len; i++) begin
          w.data  = $urandom();
          w.strb  = '1;
          w.user  = i[`AXI2AXIL_USER_W-1:0];
          w_valid = 1'b1;
          @(posedge clk);
          while (!w_ready) @(posedge clk);
          #1;
        end
        w_valid = 1'b0;
      end
    end
  endtask

  task automatic drive_reads();
    int k;
    for (k = 0; k < cases.size(); k++) begin
      if (!cases[k].is_write) begin
        ar = cases[k].req;
        ar_valid = 1'b1;
        @(posedge clk);
        while (!ar_ready) @(posedge clk);
        #1;
        ar_valid = 1'b0;
      end
    end
  endtask

  task automatic print_summary();
    $display("errors %0d, bursts checked %0d of %0d", checker_i.errors,
             checker_i.bursts_done, cases.size());
  endtask

  // Run limit from the case lengths
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles with bursts still open", limit);
      print_summary();
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    string line;
    int    fd;
    int    n;
    int    dir, a, id, len, sz, bt, eb, er;
    void'($urandom(51555));
    rst = 1'b1;
    aw = '0;
    ar = '0;
    w = '0;
    aw_valid = 1'b0;
    ar_valid = 1'b0;
    w_valid = 1'b0;
    // Unwritten words read back as the inverted address
    for (int i = 0; i < 2**(`AXI2AXIL_ADDR_W-2); i++) mem[i] = ~(32'(i) << 2);
    fd = $fopen("dv/axi2axil_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file dv/axi2axil_cases.txt");
      $display("sim failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#" &&
            $sscanf(line, "%c %h %h %h %h %h %h %h", dir, a, id, len, sz, bt, eb, er) == 8)
          load_case(dir, a, id, len, sz, bt, eb, er);
      end
      $fclose(fd);
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      fork
        drive_writes();
        drive_reads();
      join
      while (checker_i.bursts_done < cases.size()) @(posedge clk);
      // Drain window for stray beats
      repeat (20) @(posedge clk);
      checker_i.report_leftovers();
      if (cases.size() == 0) $display("no cases were read from the case file");
      print_summary();
      if (checker_i.errors == 0 && cases.size() != 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

endmodule

/* files.f */
+incdir+source
source/axi2axil_pkg.sv
source/resp_tracker_fifo.sv
source/axi2axil_core.sv
source/axi2axil_bridge.sv
dv/axi2axil_checker.sv
dv/axi2axil_tb.sv

/* source/axi2axil_bridge.sv */
// AXI4 to AXI4-Lite bridge top level
// Read and write split cores, write data passes straight through
module axi2axil_bridge import axi2axil_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // ----------------------------------------------------------------------
  // AXI4 side
  // ----------------------------------------------------------------------

  // Write address
  input  axi_req_t   aw,
  input  logic       aw_valid,
  output logic       aw_ready,
  // Write data
  input  axi_wdata_t w,
  input  logic       w_valid,
  output logic       w_ready,
  // Write response, data zero and last one
  output axi_resp_t  b,
  output logic       b_valid,
  input  logic       b_ready,
  // Read address
  input  axi_req_t   ar,
  input  logic       ar_valid,
  output logic       ar_ready,
  // Read data
  output axi_resp_t  r,
  output logic       r_valid,
  input  logic       r_ready,

  // ----------------------------------------------------------------------
  // AXI-Lite side
  // ----------------------------------------------------------------------

  output axil_req_t  axil_aw,
  output logic       axil_aw_valid,
  input  logic       axil_aw_ready,
  output axi_wdata_t axil_w,
  output logic       axil_w_valid,
  input  logic       axil_w_ready,
  input  axil_resp_t axil_b,
  input  logic       axil_b_valid,
  output logic       axil_b_ready,
  output axil_req_t  axil_ar,
  output logic       axil_ar_valid,
  input  logic       axil_ar_ready,
  input  axil_resp_t axil_r,
  input  logic       axil_r_valid,
  output logic       axil_r_ready
);

  // Write beats map one to one, no state
  assign axil_w       = w;
  assign axil_w_valid = w_valid;
  assign w_ready      = axil_w_ready;

  // aw and b
  axi2axil_core #(
    .IS_READ (1'b0)
  ) write_core (
    .clk             (clk),
    .rst             (rst),
    .axi_req         (aw),
    .axi_req_valid   (aw_valid),
    .axi_req_ready   (aw_ready),
    .axil_req        (axil_aw),
    .axil_req_valid  (axil_aw_valid),
    .axil_req_ready  (axil_aw_ready),
    .axil_resp       (axil_b),
    .axil_resp_valid (axil_b_valid),
    .axil_resp_ready (axil_b_ready),
    .axi_resp        (b),
    .axi_resp_valid  (b_valid),
    .axi_resp_ready  (b_ready)
  );

  // ar and r
  axi2axil_core #(
    .IS_READ (1'b1)
  ) read_core (
    .clk             (clk),
    .rst             (rst),
    .axi_req         (ar),
    .axi_req_valid   (ar_valid),
    .axi_req_ready   (ar_ready),
    .axil_req        (axil_ar),
    .axil_req_valid  (axil_ar_valid),
    .axil_req_ready  (axil_ar_ready),
    .axil_resp       (axil_r),
    .axil_resp_valid (axil_r_valid),
    .axil_resp_ready (axil_r_ready),
    .axi_resp        (r),
    .axi_resp_valid  (r_valid),
    .axi_resp_ready  (r_ready)
  );

endmodule

/* source/axi2axil_core.sv */
// AXI4 to AXI4-Lite split core
// Unrolls one AXI4 burst into single AXI-Lite beats and routes the
// responses back with id and last, merging write responses into one b
`include "axi2axil_settings.svh"

module axi2axil_core import axi2axil_pkg::*; #(
  parameter bit IS_READ = 1'b0
) (
  input  logic       clk,
  input  logic       rst,
  // AXI4 request
  input  axi_req_t   axi_req,
  input  logic       axi_req_valid,
  output logic       axi_req_ready,
  // AXI-Lite request
  output axil_req_t  axil_req,
  output logic       axil_req_valid,
  input  logic       axil_req_ready,
  // AXI-Lite response
  input  axil_resp_t axil_resp,
  input  logic       axil_resp_valid,
  output logic       axil_resp_ready,
  // AXI4 response
  output axi_resp_t  axi_resp,
  output logic       axi_resp_valid,
  input  logic       axi_resp_ready
);

  localparam int ADDR_W = `AXI2AXIL_ADDR_W;

  // ----------------------------------------------------------------------
  // Beat address generator
  // ----------------------------------------------------------------------

  function automatic logic [ADDR_W-1:0] beat_addr(
    input logic [ADDR_W-1:0] start,
    input logic [2:0]        size,
    input logic [7:0]        len,
    input burst_type_e       burst,
    input logic [8:0]        index
  );
    logic [ADDR_W-1:0] offset;
    logic [ADDR_W-1:0] wrap_mask;
    offset = ADDR_W'(index) << size;
    // Window is (len + 1) beats of 2^size bytes
    wrap_mask = ADDR_W'(len) + ADDR_W'(1);
    wrap_mask = (wrap_mask << size) - ADDR_W'(1);
    case (burst)
      INCR:    beat_addr = start + offset;
      WRAP:    beat_addr = (start & ~wrap_mask) | ((start + offset) & wrap_mask);
      default: beat_addr = start;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Request split
  // ----------------------------------------------------------------------

  core_state_e  state;
  core_state_e  state_next;
  axi_req_t     burst_q;
  // Beat index, len plus one carry bit
  logic [8:0]   beat_cnt;
  logic         axi_req_hs;
  logic         axil_req_hs;
  logic         axil_resp_hs;
  logic         split_last;
  tracker_tag_t push_tag;
  logic         tracker_ready;
  logic         tracker_valid;
  tracker_tag_t head_tag;

  assign axi_req_hs   = axi_req_valid && axi_req_ready;
  assign axil_req_hs  = axil_req_valid && axil_req_ready;
  assign axil_resp_hs = axil_resp_valid && axil_resp_ready;
  assign split_last   = (beat_cnt == {1'b0, burst_q.len});

  always_comb begin
    state_next     = state;
    axi_req_ready  = 1'b0;
    axil_req_valid = 1'b0;
    axil_req       = '0;
    push_tag       = '0;
    case (state)
      IDLE: begin
        // Beat 0 goes out in the acceptance cycle
        axi_req_ready  = axil_req_ready && tracker_ready;
        axil_req_valid = axi_req_valid && tracker_ready;
        axil_req.addr  = axi_req.addr;
        axil_req.prot  = axi_req.prot;
        axil_req.user  = axi_req.user;
        push_tag.id    = axi_req.id;
        push_tag.last  = (axi_req.len == 8'd0);
        if (axi_req_hs && (axi_req.len != 8'd0)) begin
          state_next = SPLIT;
        end
      end
      SPLIT: begin
        // Remaining beats from the registered burst
        axil_req_valid = tracker_ready;
        axil_req.addr  = beat_addr(burst_q.addr, burst_q.size, burst_q.len,
                                   burst_q.burst, beat_cnt);
        axil_req.prot  = burst_q.prot;
        axil_req.user  = burst_q.user;
        push_tag.id    = burst_q.id;
        push_tag.last  = split_last;
        if (axil_req_hs && split_last) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      beat_cnt <= '0;
    end else begin
      state <= state_next;
      // Reload wins, IDLE handshakes coincide
      if (axi_req_hs) begin
        beat_cnt <= 9'd1;
      end else if (axil_req_hs) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Burst fields
  always_ff @(posedge clk) begin
    if (axi_req_hs) begin
      burst_q <= axi_req;
    end
  end

  // ----------------------------------------------------------------------
  // Outstanding beat tracking
  // ----------------------------------------------------------------------

  resp_tracker_fifo tracker_i (
    .clk        (clk),
    .rst        (rst),
    .push_valid (axil_req_hs),
    .push_tag   (push_tag),
    .push_ready (tracker_ready),
    .pop_valid  (tracker_valid),
    .pop_tag    (head_tag),
    .pop_ready  (axil_resp_hs)
  );

  // ----------------------------------------------------------------------
  // Response path
  // ----------------------------------------------------------------------

  if (IS_READ) begin : gen_read
    // One r per beat, straight through
    always_comb begin
      axi_resp.id     = head_tag.id;
      axi_resp.user   = axil_resp.user;
      axi_resp.resp   = axil_resp.resp;
      axi_resp.data   = axil_resp.data;
      axi_resp.last   = head_tag.last;
      axi_resp_valid  = axil_resp_valid;
      axil_resp_ready = axi_resp_ready;
    end
  end else begin : gen_write
    resp_e merged_q;
    logic  axi_resp_hs;

    assign axi_resp_hs = axi_resp_valid && axi_resp_ready;

    // First error of the burst sticks until b goes out
    always_ff @(posedge clk) begin
      if (rst || axi_resp_hs) begin
        merged_q <= OKAY;
      end else if (axil_resp_hs && (merged_q == OKAY)) begin
        merged_q <= axil_resp.resp;
      end
    end

    // Non-last beats drain freely, last beat waits for b
    always_comb begin
      axi_resp.id     = head_tag.id;
      axi_resp.user   = axil_resp.user;
      axi_resp.resp   = (merged_q != OKAY) ? merged_q : axil_resp.resp;
      axi_resp.data   = '0;
      axi_resp.last   = 1'b1;
      axi_resp_valid  = axil_resp_valid && head_tag.last;
      axil_resp_ready = !head_tag.last || axi_resp_ready;
    end
  end

  // Responses only for beats already issued
  a_resp_has_tag: assert property (@(posedge clk) disable iff (rst)
    axil_resp_valid |-> tracker_valid);

  // Legal WRAP lengths
  a_wrap_len: assert property (@(posedge clk) disable iff (rst)
    (axi_req_valid && (axi_req.burst == WRAP)) |->
      (axi_req.len inside {8'd1, 8'd3, 8'd7, 8'd15}));

endmodule

/* source/axi2axil_pkg.sv */
// AXI4 to AXI4-Lite bridge types
// Burst and response encodings, channel payload structs
`include "axi2axil_settings.svh"

package axi2axil_pkg;

  // AXI burst encoding
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_type_e;

  // AXI response encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Split core FSM
  typedef enum logic {
    IDLE  = 1'b0,
    SPLIT = 1'b1
  } core_state_e;

  // AXI4 aw / ar payload
  typedef struct packed {
    logic [`AXI2AXIL_ADDR_W-1:0] addr;
    logic [`AXI2AXIL_ID_W-1:0]   id;
    logic [7:0]                  len;
    logic [2:0]                  size;
    burst_type_e                 burst;
    logic [2:0]                  prot;
    logic [`AXI2AXIL_USER_W-1:0] user;
  } axi_req_t;

  // Write beat, same layout on both sides
  typedef struct packed {
    logic [`AXI2AXIL_DATA_W-1:0]   data;
    logic [`AXI2AXIL_DATA_W/8-1:0] strb;
    logic [`AXI2AXIL_USER_W-1:0]   user;
  } axi_wdata_t;

  // AXI4 b / r payload
  typedef struct packed {
    logic [`AXI2AXIL_ID_W-1:0]   id;
    logic [`AXI2AXIL_USER_W-1:0] user;
    resp_e                       resp;
    logic [`AXI2AXIL_DATA_W-1:0] data;
    logic                        last;
  } axi_resp_t;

  // AXI-Lite aw / ar payload
  typedef struct packed {
    logic [`AXI2AXIL_ADDR_W-1:0] addr;
    logic [2:0]                  prot;
    logic [`AXI2AXIL_USER_W-1:0] user;
  } axil_req_t;

  // AXI-Lite b / r payload
  typedef struct packed {
    resp_e                       resp;
    logic [`AXI2AXIL_USER_W-1:0] user;
    logic [`AXI2AXIL_DATA_W-1:0] data;
  } axil_resp_t;

  // One entry per outstanding AXI-Lite beat
  typedef struct packed {
    logic [`AXI2AXIL_ID_W-1:0] id;
    logic                      last;
  } tracker_tag_t;

endpackage

/* source/axi2axil_settings.svh */
// AXI4 to AXI4-Lite bridge settings
// Bus widths and response tracker depth
`ifndef AXI2AXIL_SETTINGS_SVH
`define AXI2AXIL_SETTINGS_SVH

// Byte address width on both sides
`define AXI2AXIL_ADDR_W 16

// Data width, strobes are one bit per byte
`define AXI2AXIL_DATA_W 32

// AXI4 transaction id width
`define AXI2AXIL_ID_W 4

// Sideband user width for requests and responses
`define AXI2AXIL_USER_W 4

// Outstanding AXI-Lite beats per core
// Must be 2 or more
`define AXI2AXIL_MAX_OUTSTANDING 8

`endif

/* source/resp_tracker_fifo.sv */
// Response tracker FIFO
// Holds id and last-beat flag of each outstanding AXI-Lite request
`include "axi2axil_settings.svh"

module resp_tracker_fifo import axi2axil_pkg::*; #(
  parameter int DEPTH = `AXI2AXIL_MAX_OUTSTANDING
) (
  input  logic         clk,
  input  logic         rst,
  // Push side
  input  logic         push_valid,
  input  tracker_tag_t push_tag,
  output logic         push_ready,
  // Pop side
  output logic         pop_valid,
  output tracker_tag_t pop_tag,
  input  logic         pop_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  tracker_tag_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Full and empty flags from occupancy
  assign push_ready = (count != CNT_W'(DEPTH));
  assign pop_valid  = (count != '0);
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop_ready && pop_valid;

  // No bypass, head comes straight from storage
  assign pop_tag = mem[rd_ptr];

  // Tag storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_tag;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Requester must respect the full flag
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) push_valid |-> push_ready);
  // Consumer only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop_ready |-> pop_valid);

endmodule
